//--- Makefile
VERILATOR ?= verilator
TOP ?= complexFirTb
FILE_LIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= sim failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src.f
verilog/firPkg.sv
verilog/firInterfaces.sv
verilog/coeffLoader.sv
verilog/sampleDelayLine.sv
verilog/complexMac.sv
verilog/outputScaler.sv
verilog/complexFirTop.sv
tests/complexFirTb.sv

//--- tests/complexFirTb.sv
// Complex FIR filter testbench
module complexFirTb;

	timeunit 1ns;
	timeprecision 1ps;

	import firPkg::*;

	// The output is narrower than the default so that full-scale inputs reach the clamp.
	localparam int TAPS = TAPS_DEFAULT;
	localparam int DATA_WIDTH = DATA_WIDTH_DEFAULT;
	localparam int OUT_WIDTH = 12;
	localparam int OUT_SHIFT = OUT_SHIFT_DEFAULT;
	localparam int LATENCY = 5;
	localparam int DRAIN_LIMIT = 4 * LATENCY;
	localparam int READY_LIMIT = 4;
	// An impulse of one output step makes each output equal to h[k].
	localparam int IMPULSE = 1 << OUT_SHIFT;

	logic clock;
	logic reset;
	logic coeffStart;
	logic coeffValid;
	logic signed [DATA_WIDTH-1:0] coeffInRe;
	logic signed [DATA_WIDTH-1:0] coeffInIm;
	logic coeffsReady;
	logic sampleValid;
	logic signed [DATA_WIDTH-1:0] sampleInRe;
	logic signed [DATA_WIDTH-1:0] sampleInIm;
	logic outValid;
	logic signed [OUT_WIDTH-1:0] outRe;
	logic signed [OUT_WIDTH-1:0] outIm;
	logic outOverflow;

	// Reference model state. History index 0 is the newest sample.
	int histRe [TAPS];
	int histIm [TAPS];
	int bankRe [TAPS];
	int bankIm [TAPS];
	int loadIndex = 0;
	bit loadFilling = 1'b0;
	bit loadFull = 1'b0;

	// Expected outputs, in order, with the cycle on which each must appear.
	int expRe [$];
	int expIm [$];
	bit expOvf [$];
	int expCycle [$];

	int cycleCount = 0;
	logic [31:0] lfsr;

	complexFirTop #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH),
		.OUT_WIDTH(OUT_WIDTH),
		.OUT_SHIFT(OUT_SHIFT)
	) u_dut (
		.clock(clock),
		.reset(reset),
		.coeffStart(coeffStart),
		.coeffValid(coeffValid),
		.coeffInRe(coeffInRe),
		.coeffInIm(coeffInIm),
		.coeffsReady(coeffsReady),
		.sampleValid(sampleValid),
		.sampleInRe(sampleInRe),
		.sampleInIm(sampleInIm),
		.outValid(outValid),
		.outRe(outRe),
		.outIm(outIm),
		.outOverflow(outOverflow)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Counts rising edges. It is read on falling edges only, where it is stable.
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
	end

	task automatic stopWithFailure(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "stopped at the first failure");
	endtask

	function automatic string errLine(input string msg);
		return $sformatf("ERR %0t: %s", $time, msg);
	endfunction

	// Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken.
	function automatic int randomBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrStep(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
		return value;
	endfunction

	function automatic int randomSigned();
		int value;
		value = randomBits(DATA_WIDTH);
		if (value >= (1 << (DATA_WIDTH - 1))) begin
			value = value - (1 << DATA_WIDTH);
		end
		return value;
	endfunction

	// Round half up, shift right arithmetically, then clamp to the signed output range.
	function automatic int roundAndClamp(input longint acc, output bit clamped);
		longint half;
		longint maxOut;
		longint shifted;
		half = (OUT_SHIFT > 0) ? (longint'(1) << (OUT_SHIFT - 1)) : 0;
		maxOut = (longint'(1) << (OUT_WIDTH - 1)) - 1;
		shifted = (acc + half) >>> OUT_SHIFT;
		clamped = 1'b0;
		if (shifted > maxOut) begin
			shifted = maxOut;
			clamped = 1'b1;
		end else if (shifted < -maxOut - 1) begin
			shifted = -maxOut - 1;
			clamped = 1'b1;
		end
		return int'(shifted);
	endfunction

	// A start empties the bank and begins a new fill.
	function automatic void modelStart();
		for (int k = 0; k < TAPS; k++) begin
			bankRe[k] = 0;
			bankIm[k] = 0;
		end
		loadIndex = 0;
		loadFilling = 1'b1;
		loadFull = 1'b0;
	endfunction

	// Writes are ignored unless the bank is filling.
	function automatic void modelWrite(input int re, input int im);
		if (loadFilling) begin
			bankRe[loadIndex] = re;
			bankIm[loadIndex] = im;
			loadIndex++;
			if (loadIndex == TAPS) begin
				loadFilling = 1'b0;
				loadFull = 1'b1;
			end
		end
	endfunction

	// Shifts the sample into the history and queues y[n] = sum of h[k] x[n-k].
	function automatic void modelSample(input int re, input int im);
		longint accRe;
		longint accIm;
		bit clampRe;
		bit clampIm;
		for (int k = TAPS - 1; k > 0; k--) begin
			histRe[k] = histRe[k-1];
			histIm[k] = histIm[k-1];
		end
		histRe[0] = re;
		histIm[0] = im;
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < TAPS; k++) begin
			accRe += longint'(histRe[k]) * bankRe[k] - longint'(histIm[k]) * bankIm[k];
			accIm += longint'(histRe[k]) * bankIm[k] + longint'(histIm[k]) * bankRe[k];
		end
		expRe.push_back(roundAndClamp(accRe, clampRe));
		expIm.push_back(roundAndClamp(accIm, clampIm));
		expOvf.push_back(clampRe || clampIm);
		expCycle.push_back(cycleCount + LATENCY);
	endfunction

	// Drives one cycle of inputs on the falling edge and updates the model to match.
	// Coefficient updates go first, since a sample sees the bank of its own edge.
	task automatic driveCycle(input bit start, input bit cValid, input int cRe, input int cIm,
		input bit sValid, input int sRe, input int sIm);
		@(negedge clock);
		assert (coeffsReady == loadFull)
			else stopWithFailure(errLine($sformatf("coeffsReady is %0b, expected %0b",
				coeffsReady, loadFull)));
		coeffStart = start;
		coeffValid = cValid;
		coeffInRe = DATA_WIDTH'(cRe);
		coeffInIm = DATA_WIDTH'(cIm);
		sampleValid = sValid;
		sampleInRe = DATA_WIDTH'(sRe);
		sampleInIm = DATA_WIDTH'(sIm);
		if (start) begin
			modelStart();
		end
		if (cValid) begin
			modelWrite(cRe, cIm);
		end
		if (sValid) begin
			modelSample(sRe, sIm);
		end
	endtask

	task automatic idleCycle();
		driveCycle(1'b0, 1'b0, 0, 0, 1'b0, 0, 0);
	endtask

	task automatic sendSample(input int re, input int im);
		driveCycle(1'b0, 1'b0, 0, 0, 1'b1, re, im);
	endtask

	// Idles until every queued output has been seen.
	task automatic waitForDrain();
		int waited;
		waited = 0;
		while (expRe.size() > 0) begin
			idleCycle();
			waited++;
			if (waited > DRAIN_LIMIT) begin
				stopWithFailure($sformatf("Timed out at %0t with %0d outputs still missing.",
					$time, expRe.size()));
			end
		end
	endtask

	// Loads a full bank, either random or with one fixed value in every entry.
	task automatic loadBank(input bit useRandom, input int fixedRe, input int fixedIm);
		int re;
		int im;
		int waited;
		driveCycle(1'b1, 1'b0, 0, 0, 1'b0, 0, 0);
		for (int k = 0; k < TAPS; k++) begin
			re = useRandom ? randomSigned() : fixedRe;
			im = useRandom ? randomSigned() : fixedIm;
			driveCycle(1'b0, 1'b1, re, im, 1'b0, 0, 0);
		end
		waited = 0;
		while (!coeffsReady) begin
			idleCycle();
			waited++;
			if (waited > READY_LIMIT) begin
				stopWithFailure($sformatf("Timed out at %0t waiting for coeffsReady.", $time));
			end
		end
	endtask

	// Output checker. Each output must match the head of the queue on its exact cycle.
	always @(negedge clock) begin
		if (!reset && outValid) begin
			assert (expRe.size() > 0)
				else stopWithFailure(errLine("output seen with no sample pending"));
			assert (cycleCount == expCycle[0])
				else stopWithFailure(errLine($sformatf("output on cycle %0d, expected %0d",
					cycleCount, expCycle[0])));
			assert ((outRe == expRe[0]) && (outIm == expIm[0]))
				else stopWithFailure(errLine($sformatf("output (%0d, %0d), expected (%0d, %0d)",
					outRe, outIm, expRe[0], expIm[0])));
			assert (outOverflow == expOvf[0])
				else stopWithFailure(errLine($sformatf("outOverflow is %0b, expected %0b",
					outOverflow, expOvf[0])));
			void'(expRe.pop_front());
			void'(expIm.pop_front());
			void'(expOvf.pop_front());
			void'(expCycle.pop_front());
		end else if (!reset && (expCycle.size() > 0)) begin
			assert (expCycle[0] > cycleCount)
				else stopWithFailure(errLine("expected output did not appear"));
		end
	end

	// With an empty bank the first samples give zero, then a load raises coeffsReady.
	task automatic checkResetAndLoad();
		@(negedge clock);
		assert (!coeffsReady && !outValid)
			else stopWithFailure(errLine("coeffsReady or outValid high after reset"));
		for (int n = 0; n < 3; n++) begin
			sendSample(randomSigned(), randomSigned());
		end
		waitForDrain();
		loadBank(1'b1, 0, 0);
	endtask

	// Flush the history with zeros, then one impulse walks through every tap.
	task automatic checkImpulse();
		loadBank(1'b1, 0, 0);
		for (int n = 0; n < TAPS; n++) begin
			sendSample(0, 0);
		end
		sendSample(IMPULSE, 0);
		for (int n = 0; n < TAPS + 2; n++) begin
			sendSample(0, 0);
		end
		waitForDrain();
	endtask

	task automatic checkRandomStream(input int count);
		int gap;
		for (int n = 0; n < count; n++) begin
			gap = randomBits(2);
			repeat (gap) idleCycle();
			sendSample(randomSigned(), randomSigned());
		end
		waitForDrain();
	endtask

	// 127+127j times 127-127j is purely real and large, well past the clamp.
	task automatic checkSaturation();
		int maxVal;
		maxVal = (1 << (DATA_WIDTH - 1)) - 1;
		loadBank(1'b0, maxVal, -maxVal);
		for (int n = 0; n < TAPS + 2; n++) begin
			sendSample(maxVal, maxVal);
		end
		assert (expOvf[expOvf.size() - 1])
			else stopWithFailure("The full-scale stimulus does not reach the clamp.");
		waitForDrain();
		for (int n = 0; n < TAPS + 2; n++) begin
			sendSample(1, 1);
		end
		waitForDrain();
	endtask

	// A start in mid-stream, then writes interleaved with samples and a few extra writes.
	task automatic checkReload();
		for (int n = 0; n < 4; n++) begin
			sendSample(randomSigned(), randomSigned());
		end
		driveCycle(1'b1, 1'b0, 0, 0, 1'b1, randomSigned(), randomSigned());
		for (int k = 0; k < TAPS + 3; k++) begin
			driveCycle(1'b0, 1'b1, randomSigned(), randomSigned(),
				randomBits(1) != 0, randomSigned(), randomSigned());
		end
		for (int n = 0; n < TAPS; n++) begin
			sendSample(randomSigned(), randomSigned());
		end
		waitForDrain();
		assert (coeffsReady)
			else stopWithFailure(errLine("coeffsReady low after the reload"));
	endtask

	initial begin
		lfsr = 32'hbf04_2dd7;
		reset = 1'b1;
		coeffStart = 1'b0;
		coeffValid = 1'b0;
		coeffInRe = '0;
		coeffInIm = '0;
		sampleValid = 1'b0;
		sampleInRe = '0;
		sampleInIm = '0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		checkResetAndLoad();
		checkImpulse();
		checkRandomStream(200);
		checkSaturation();
		checkReload();
		checkRandomStream(50);

		$display("sim passed");
		$finish;
	end

endmodule

//--- verilog/coeffLoader.sv
// Coefficient bank loader
module coeffLoader #(
	parameter int TAPS = firPkg::TAPS_DEFAULT,
	parameter int DATA_WIDTH = firPkg::DATA_WIDTH_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic coeffStart,
	input logic coeffValid,
	input logic signed [DATA_WIDTH-1:0] coeffInRe,
	input logic signed [DATA_WIDTH-1:0] coeffInIm,
	output logic coeffsReady,
	tapWindowIf.coeffs window
);

	import firPkg::*;

	// The write index has to reach TAPS itself, one past the last entry.
	localparam int IDX_W = $clog2(TAPS + 1);
	localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(TAPS - 1);
	localparam logic [IDX_W-1:0] FULL_INDEX = IDX_W'(TAPS);

	loaderState state;
	logic [IDX_W-1:0] writeIndex;
	logic signed [DATA_WIDTH-1:0] bankRe [TAPS];
	logic signed [DATA_WIDTH-1:0] bankIm [TAPS];

	// A write is taken only while the bank is filling.
	logic writeEnable;
	assign writeEnable = (state == LOAD_FILL) && coeffValid;

	// Load FSM. A start pulse always restarts the fill, even from a full bank.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= LOAD_IDLE;
			writeIndex <= '0;
		end else if (coeffStart) begin
			state <= LOAD_FILL;
			writeIndex <= '0;
		end else if (writeEnable) begin
			writeIndex <= writeIndex + 1'b1;
			// The last write completes the bank.
			if (writeIndex == LAST_INDEX) begin
				state <= LOAD_FULL;
			end
		end
	end

	// Bank storage. Each entry compares its own position against the index,
	// so only one entry is written per strobe.
	always_ff @(posedge clock) begin
		for (int k = 0; k < TAPS; k++) begin
			if (reset || coeffStart) begin
				bankRe[k] <= '0;
				bankIm[k] <= '0;
			end else if (writeEnable && (writeIndex == IDX_W'(k))) begin
				bankRe[k] <= coeffInRe;
				bankIm[k] <= coeffInIm;
			end
		end
	end

	assign window.coeffRe = bankRe;
	assign window.coeffIm = bankIm;

	// Ready only once every entry has been written since the last start.
	assign coeffsReady = (state == LOAD_FULL);

	// A start and a write in the same cycle would lose the write.
	assert property (@(posedge clock) disable iff (reset) !(coeffStart && coeffValid))
		else $error("coeffStart and coeffValid high together");

	// The index stays in range, and sits at TAPS exactly when the bank is full.
	assert property (@(posedge clock) disable iff (reset)
		(writeIndex <= FULL_INDEX) && ((state == LOAD_FULL) == (writeIndex == FULL_INDEX)))
		else $error("write index out of step with loader state");

endmodule

//--- verilog/complexFirTop.sv
// Complex FIR filter top level
module complexFirTop #(
	parameter int TAPS = firPkg::TAPS_DEFAULT,
	parameter int DATA_WIDTH = firPkg::DATA_WIDTH_DEFAULT,
	parameter int OUT_WIDTH = firPkg::OUT_WIDTH_DEFAULT,
	parameter int OUT_SHIFT = firPkg::OUT_SHIFT_DEFAULT
) (
	input logic clock,
	input logic reset,
	// Coefficient load port.
	input logic coeffStart,
	input logic coeffValid,
	input logic signed [DATA_WIDTH-1:0] coeffInRe,
	input logic signed [DATA_WIDTH-1:0] coeffInIm,
	output logic coeffsReady,
	// Sample stream in.
	input logic sampleValid,
	input logic signed [DATA_WIDTH-1:0] sampleInRe,
	input logic signed [DATA_WIDTH-1:0] sampleInIm,
	// Filtered stream out, five cycles behind the sample strobe.
	output logic outValid,
	output logic signed [OUT_WIDTH-1:0] outRe,
	output logic signed [OUT_WIDTH-1:0] outIm,
	output logic outOverflow
);

	import firPkg::*;

	localparam int ACC_W = accWidth(DATA_WIDTH, TAPS);

	// Multiply-accumulate to scaler link.
	logic sumValid;
	logic signed [ACC_W-1:0] sumRe;
	logic signed [ACC_W-1:0] sumIm;

	// Window and bank shared by the input side and the multiply-accumulate.
	tapWindowIf #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) tapWindow ();

	// The bank is loaded in parallel with filtering; the filter always uses
	// whatever the bank holds.
	coeffLoader #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) loader (
		.clock(clock),
		.reset(reset),
		.coeffStart(coeffStart),
		.coeffValid(coeffValid),
		.coeffInRe(coeffInRe),
		.coeffInIm(coeffInIm),
		.coeffsReady(coeffsReady),
		.window(tapWindow.coeffs)
	);

	sampleDelayLine #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) delayLine (
		.clock(clock),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleInRe(sampleInRe),
		.sampleInIm(sampleInIm),
		.window(tapWindow.samples)
	);

	complexMac #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) mac (
		.clock(clock),
		.reset(reset),
		.window(tapWindow.mac),
		.sumValid(sumValid),
		.sumRe(sumRe),
		.sumIm(sumIm)
	);

	outputScaler #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH),
		.OUT_WIDTH(OUT_WIDTH),
		.OUT_SHIFT(OUT_SHIFT)
	) scaler (
		.clock(clock),
		.reset(reset),
		.sumValid(sumValid),
		.sumRe(sumRe),
		.sumIm(sumIm),
		.outValid(outValid),
		.outOverflow(outOverflow),
		.outRe(outRe),
		.outIm(outIm)
	);

endmodule

//--- verilog/complexMac.sv
// Pipelined complex multiply-accumulate
module complexMac #(
	parameter int TAPS = firPkg::TAPS_DEFAULT,
	parameter int DATA_WIDTH = firPkg::DATA_WIDTH_DEFAULT
) (
	input logic clock,
	input logic reset,
	tapWindowIf.mac window,
	output logic sumValid,
	output logic signed [firPkg::accWidth(DATA_WIDTH, TAPS)-1:0] sumRe,
	output logic signed [firPkg::accWidth(DATA_WIDTH, TAPS)-1:0] sumIm
);

	import firPkg::*;

	localparam int PROD_W = 2 * DATA_WIDTH;
	localparam int ACC_W = accWidth(DATA_WIDTH, TAPS);

	// Stage valid bits.
	logic valid1;
	logic valid2;

	// Stage 1 products. The first letter names the sample part, the second
	// the coefficient part, so prodRi is sampleRe times coeffIm.
	logic signed [PROD_W-1:0] prodRr [TAPS];
	logic signed [PROD_W-1:0] prodIi [TAPS];
	logic signed [PROD_W-1:0] prodRi [TAPS];
	logic signed [PROD_W-1:0] prodIr [TAPS];

	// Combinational tap sums feeding stage 2.
	logic signed [ACC_W-1:0] treeRr;
	logic signed [ACC_W-1:0] treeIi;
	logic signed [ACC_W-1:0] treeRi;
	logic signed [ACC_W-1:0] treeIr;

	// Stage 2 registered tap sums.
	logic signed [ACC_W-1:0] sumRr;
	logic signed [ACC_W-1:0] sumIi;
	logic signed [ACC_W-1:0] sumRi;
	logic signed [ACC_W-1:0] sumIr;

	// Valid shift register, one bit per stage.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			sumValid <= 1'b0;
		end else begin
			valid1 <= window.windowValid;
			valid2 <= valid1;
			sumValid <= valid2;
		end
	end

	// Stage 1. Four real products per tap; h[k] pairs with the sample at index k.
	// Operands are widened first so the product keeps its full precision.
	always_ff @(posedge clock) begin
		if (window.windowValid) begin
			for (int k = 0; k < TAPS; k++) begin
				prodRr[k] <= PROD_W'(window.sampleRe[k]) * PROD_W'(window.coeffRe[k]);
				prodIi[k] <= PROD_W'(window.sampleIm[k]) * PROD_W'(window.coeffIm[k]);
				prodRi[k] <= PROD_W'(window.sampleRe[k]) * PROD_W'(window.coeffIm[k]);
				prodIr[k] <= PROD_W'(window.sampleIm[k]) * PROD_W'(window.coeffRe[k]);
			end
		end
	end

	// Reduce each product array to one sum. Synthesis is free to rebalance
	// this chain into a tree.
	always_comb begin
		treeRr = '0;
		treeIi = '0;
		treeRi = '0;
		treeIr = '0;
		for (int k = 0; k < TAPS; k++) begin
			treeRr = treeRr + ACC_W'(prodRr[k]);
			treeIi = treeIi + ACC_W'(prodIi[k]);
			treeRi = treeRi + ACC_W'(prodRi[k]);
			treeIr = treeIr + ACC_W'(prodIr[k]);
		end
	end

	// Stage 2 registers the four tap sums.
	always_ff @(posedge clock) begin
		if (valid1) begin
			sumRr <= treeRr;
			sumIi <= treeIi;
			sumRi <= treeRi;
			sumIr <= treeIr;
		end
	end

	// Stage 3. (a+jb)(c+jd) = (ac - bd) + j(ad + bc).
	always_ff @(posedge clock) begin
		if (valid2) begin
			sumRe <= sumRr - sumIi;
			sumIm <= sumRi + sumIr;
		end
	end

	// Every window yields exactly one sum, three cycles later.
	assert property (@(posedge clock) disable iff (reset)
		sumValid == $past(window.windowValid, 3))
		else $error("sumValid out of step with windowValid");

endmodule

//--- verilog/firInterfaces.sv
// Tap window interface
interface tapWindowIf #(
	parameter int TAPS = firPkg::TAPS_DEFAULT,
	parameter int DATA_WIDTH = firPkg::DATA_WIDTH_DEFAULT
);

	// Pulses for one cycle whenever the sample window has just taken a new sample.
	logic windowValid;

	// Sample window. Index 0 holds the newest sample, index TAPS-1 the oldest.
	logic signed [DATA_WIDTH-1:0] sampleRe [TAPS];
	logic signed [DATA_WIDTH-1:0] sampleIm [TAPS];

	// Coefficient bank. Index k holds h[k], so h[0] meets the newest sample.
	logic signed [DATA_WIDTH-1:0] coeffRe [TAPS];
	logic signed [DATA_WIDTH-1:0] coeffIm [TAPS];

	// The delay line owns the window and its valid strobe.
	modport samples (
		output windowValid,
		output sampleRe,
		output sampleIm
	);

	// The loader owns the bank.
	modport coeffs (
		output coeffRe,
		output coeffIm
	);

	// The multiply-accumulate only reads.
	modport mac (
		input windowValid,
		input sampleRe,
		input sampleIm,
		input coeffRe,
		input coeffIm
	);

endinterface

//--- verilog/firPkg.sv
// FIR filter shared definitions
package firPkg;

	// Default number of filter taps.
	localparam int TAPS_DEFAULT = 8;

	// Default width of the real and imaginary parts of samples and coefficients.
	localparam int DATA_WIDTH_DEFAULT = 8;

	// Default width of each output part after scaling.
	localparam int OUT_WIDTH_DEFAULT = 16;

	// Default right shift applied before saturation.
	localparam int OUT_SHIFT_DEFAULT = 4;

	// Width of the accumulated sums. A product of two parts needs twice the data
	// width, the tap sum grows by the log of the tap count, and the final complex
	// combine adds or subtracts two such sums, which costs one guard bit.
	function automatic int accWidth(input int dataWidth, input int taps);
		return 2 * dataWidth + $clog2(taps) + 1;
	endfunction

	// States of the coefficient loader.
	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_FILL,
		LOAD_FULL
	} loaderState;

endpackage

//--- verilog/outputScaler.sv
// Output rounding and saturation
module outputScaler #(
	parameter int TAPS = firPkg::TAPS_DEFAULT,
	parameter int DATA_WIDTH = firPkg::DATA_WIDTH_DEFAULT,
	parameter int OUT_WIDTH = firPkg::OUT_WIDTH_DEFAULT,
	parameter int OUT_SHIFT = firPkg::OUT_SHIFT_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic sumValid,
	input logic signed [firPkg::accWidth(DATA_WIDTH, TAPS)-1:0] sumRe,
	input logic signed [firPkg::accWidth(DATA_WIDTH, TAPS)-1:0] sumIm,
	output logic outValid,
	output logic outOverflow,
	output logic signed [OUT_WIDTH-1:0] outRe,
	output logic signed [OUT_WIDTH-1:0] outIm
);

	import firPkg::*;

	localparam int ACC_W = accWidth(DATA_WIDTH, TAPS);
	// Working width covers the rounding carry and the widest clamp bound.
	localparam int WIDE_W = ((ACC_W + 1 > OUT_WIDTH) ? ACC_W + 1 : OUT_WIDTH) + 1;
	localparam int ROUND_POS = (OUT_SHIFT > 0) ? OUT_SHIFT - 1 : 0;
	localparam logic signed [WIDE_W-1:0] ROUND_HALF =
		(OUT_SHIFT > 0) ? (WIDE_W'(1) << ROUND_POS) : '0;
	// Largest positive output; its complement is the most negative one.
	localparam logic signed [WIDE_W-1:0] MAX_OUT =
		{{(WIDE_W - OUT_WIDTH + 1){1'b0}}, {(OUT_WIDTH - 1){1'b1}}};
	localparam logic signed [WIDE_W-1:0] MIN_OUT = ~MAX_OUT;

	logic signed [OUT_WIDTH-1:0] scaledRe;
	logic signed [OUT_WIDTH-1:0] scaledIm;
	logic clampRe;
	logic clampIm;

	// Round half up, shift, then clamp. Returns high when the value was clamped.
	function automatic logic scalePart(input logic signed [ACC_W-1:0] value,
		output logic signed [OUT_WIDTH-1:0] scaled);
		logic signed [WIDE_W-1:0] wide;
		wide = value;
		wide = (wide + ROUND_HALF) >>> OUT_SHIFT;
		if (wide > MAX_OUT) begin
			scaled = MAX_OUT[OUT_WIDTH-1:0];
			return 1'b1;
		end
		if (wide < MIN_OUT) begin
			scaled = MIN_OUT[OUT_WIDTH-1:0];
			return 1'b1;
		end
		scaled = wide[OUT_WIDTH-1:0];
		return 1'b0;
	endfunction

	always_comb begin
		clampRe = scalePart(sumRe, scaledRe);
		clampIm = scalePart(sumIm, scaledIm);
	end

	// The overflow flag is qualified by valid, so it never lingers between outputs.
	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
			outOverflow <= 1'b0;
		end else begin
			outValid <= sumValid;
			outOverflow <= sumValid && (clampRe || clampIm);
		end
	end

	always_ff @(posedge clock) begin
		if (sumValid) begin
			outRe <= scaledRe;
			outIm <= scaledIm;
		end
	end

endmodule

//--- verilog/sampleDelayLine.sv
// Complex sample delay line
module sampleDelayLine #(
	parameter int TAPS = firPkg::TAPS_DEFAULT,
	parameter int DATA_WIDTH = firPkg::DATA_WIDTH_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic sampleValid,
	input logic signed [DATA_WIDTH-1:0] sampleInRe,
	input logic signed [DATA_WIDTH-1:0] sampleInIm,
	tapWindowIf.samples window
);

	// The valid strobe follows the sample strobe by one cycle, together with
	// the window it describes.
	always_ff @(posedge clock) begin
		if (reset) begin
			window.windowValid <= 1'b0;
		end else begin
			window.windowValid <= sampleValid;
		end
	end

	// Window shift. The history is cleared on reset so that the first outputs
	// see zeros in the older taps.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < TAPS; k++) begin
				window.sampleRe[k] <= '0;
				window.sampleIm[k] <= '0;
			end
		end else if (sampleValid) begin
			// Every entry moves one place towards the old end.
			for (int k = TAPS - 1; k > 0; k--) begin
				window.sampleRe[k] <= window.sampleRe[k-1];
				window.sampleIm[k] <= window.sampleIm[k-1];
			end
			// The new sample enters at the front.
			window.sampleRe[0] <= sampleInRe;
			window.sampleIm[0] <= sampleInIm;
		end
		// No strobe, no shift. Gaps leave the window as it was.
	end

	// A valid window always carries the sample strobed one cycle earlier at
	// its front.
	assert property (@(posedge clock) disable iff (reset)
		window.windowValid |-> ($past(sampleValid)
			&& (window.sampleRe[0] == $past(sampleInRe))
			&& (window.sampleIm[0] == $past(sampleInIm))))
		else $error("windowValid without a preceding sample strobe");

endmodule
